/* design/xv_pkg.sv */
`default_nettype none

package xv_pkg;
    // vram geometry
    localparam int VRAM_AW = 8;                 // word address, 256 words
    localparam int VRAM_DW = 16;                // word width

    // horizontal raster, in pixels
    localparam int H_VISIBLE = 8;
    localparam int H_FRONT   = 1;
    localparam int H_SYNC    = 2;
    localparam int H_BACK    = 1;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

    // vertical raster, in lines
    localparam int V_VISIBLE = 4;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 1;
    localparam int V_BACK    = 1;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    localparam int H_CW = $clog2(H_TOTAL);      // horizontal counter width
    localparam int V_CW = $clog2(V_TOTAL);      // vertical counter width

    // host register numbers
    localparam logic [3:0] REG_ADDR = 4'h0;     // address pointer
    localparam logic [3:0] REG_DATA = 4'h1;     // data write / read latch
    localparam logic [3:0] REG_CTRL = 4'h3;     // control and status

    // bus encodings
    localparam logic CS_ENABLED  = 1'b0;        // bus_cs_n_i active level
    localparam logic RNW_READ    = 1'b1;
    localparam logic RNW_WRITE   = 1'b0;
    localparam logic SYNC_ACTIVE = 1'b0;        // both syncs active low
endpackage

`default_nettype wire

/* design/xv_vram.sv */
`default_nettype none
`timescale 1ns/1ns

module xv_vram (
    input  logic                        clk,
    input  logic                        sel_i,      // port enable
    input  logic                        wr_en_i,
    input  logic [xv_pkg::VRAM_AW-1:0]  addr_i,     // word address
    input  logic [xv_pkg::VRAM_DW-1:0]  wdata_i,
    output logic [xv_pkg::VRAM_DW-1:0]  rdata_o     // valid the cycle after sel_i
);
    import xv_pkg::*;

    logic [VRAM_DW-1:0] mem [0:(1 << VRAM_AW) - 1];     // maps to block ram

    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (wr_en_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];     // old word on a write
        end
    end

endmodule

`default_nettype wire

/* design/xv_vram_ctrl.sv */
`default_nettype none
`timescale 1ns/1ns

module xv_vram_ctrl (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        vid_rd_i,       // video fetch, always wins
    input  logic [xv_pkg::VRAM_AW-1:0]  vid_addr_i,
    input  logic                        bus_wr_req_i,   // level until ack
    input  logic                        bus_rd_req_i,   // level until ack
    input  logic [xv_pkg::VRAM_AW-1:0]  bus_addr_i,
    input  logic [xv_pkg::VRAM_DW-1:0]  bus_wdata_i,
    output logic                        bus_ack_o,      // pulse in the grant cycle
    output logic                        bus_rd_valid_o, // mem_rdata_o is the bus word
    output logic [xv_pkg::VRAM_DW-1:0]  mem_rdata_o
);
    import xv_pkg::*;

    logic               bus_grant;  // bus owns the port this cycle
    logic               mem_sel;
    logic               mem_wr;
    logic [VRAM_AW-1:0] mem_addr;
    logic               rd_valid_q;

    always_comb begin
        bus_grant = !vid_rd_i && (bus_wr_req_i || bus_rd_req_i);   // free cycles only
        mem_sel   = vid_rd_i || bus_grant;
        mem_wr    = bus_grant && bus_wr_req_i;
        mem_addr  = vid_rd_i ? vid_addr_i : bus_addr_i;
    end

    // mark the word returning from a bus read
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= bus_grant && bus_rd_req_i;
        end
    end

    xv_vram vram0 (
        .clk     (clk),
        .sel_i   (mem_sel),
        .wr_en_i (mem_wr),
        .addr_i  (mem_addr),
        .wdata_i (bus_wdata_i),     // only the bus writes
        .rdata_o (mem_rdata_o)
    );

    assign bus_ack_o      = bus_grant;
    assign bus_rd_valid_o = rd_valid_q;

endmodule

`default_nettype wire

/* design/xv_bus_regs.sv */
`default_nettype none
`timescale 1ns/1ns

module xv_bus_regs (
    input  logic                        clk,            // pixel clock
    input  logic                        rst_n_i,
    input  logic                        bus_cs_n_i,     // one-cycle select strobe
    input  logic                        bus_rd_nwr_i,   // 1 read, 0 write
    input  logic [3:0]                  bus_reg_num_i,
    input  logic                        bus_bytesel_i,  // 0 even (high), 1 odd (low)
    input  logic [7:0]                  bus_data_i,
    input  logic                        bus_ack_i,      // request served this cycle
    input  logic                        bus_rd_valid_i, // mem_rdata_i holds our word
    input  logic [xv_pkg::VRAM_DW-1:0]  mem_rdata_i,
    output logic [7:0]                  bus_data_o,
    output logic                        bus_wr_req_o,
    output logic                        bus_rd_req_o,
    output logic [xv_pkg::VRAM_AW-1:0]  bus_addr_o,
    output logic [xv_pkg::VRAM_DW-1:0]  bus_wdata_o,
    output logic                        video_ena_o
);
    import xv_pkg::*;

    logic               wr_stb;     // host write this cycle
    logic               rd_stb;     // host read this cycle
    logic               busy;       // a vram request is still pending
    logic               addr_wr;    // accepted pointer write
    logic               data_wr;    // accepted data write
    logic               ctrl_wr;
    logic [7:0]         hi_q;       // pending even byte
    logic [VRAM_AW-1:0] addr_q;     // address pointer
    logic [VRAM_DW-1:0] wdata_q;    // assembled write word
    logic [VRAM_DW-1:0] latch_q;    // read latch
    logic               wr_req_q;
    logic               rd_req_q;
    logic               ena_q;      // video enable
    logic [7:0]         rdata_q;    // host read register

    always_comb begin
        wr_stb  = (bus_cs_n_i == CS_ENABLED) && (bus_rd_nwr_i == RNW_WRITE);
        rd_stb  = (bus_cs_n_i == CS_ENABLED) && (bus_rd_nwr_i == RNW_READ);
        busy    = wr_req_q || rd_req_q;
        // pointer and data writes dropped while a request waits
        addr_wr = wr_stb && !busy && (bus_reg_num_i == REG_ADDR);
        data_wr = wr_stb && !busy && (bus_reg_num_i == REG_DATA);
        ctrl_wr = wr_stb && (bus_reg_num_i == REG_CTRL) && bus_bytesel_i;  // bit 0 in odd byte
    end

    // request levels, pointer and enable
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_q   <= '0;
            wr_req_q <= 1'b0;
            rd_req_q <= 1'b0;
            ena_q    <= 1'b0;
        end else begin
            if (bus_ack_i) begin            // level drops the cycle after ack
                wr_req_q <= 1'b0;
                rd_req_q <= 1'b0;
                if (wr_req_q) begin
                    addr_q <= addr_q + 1'b1;    // post-write increment, wraps at 255
                end
            end
            if (addr_wr && bus_bytesel_i) begin
                addr_q   <= VRAM_AW'({hi_q, bus_data_i});  // bits past the vram dropped
                rd_req_q <= 1'b1;           // prefetch into the latch
            end
            if (data_wr && bus_bytesel_i) begin
                wr_req_q <= 1'b1;
            end
            if (ctrl_wr) begin
                ena_q <= bus_data_i[0];
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if ((addr_wr || data_wr) && !bus_bytesel_i) begin
            hi_q <= bus_data_i;             // even byte waits for its partner
        end
        if (data_wr && bus_bytesel_i) begin
            wdata_q <= {hi_q, bus_data_i};
        end
        if (bus_rd_valid_i) begin
            latch_q <= mem_rdata_i;         // word from the prefetch
        end
    end

    // host read mux, registered and held between reads
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= 8'h00;
        end else if (rd_stb) begin
            case (bus_reg_num_i)
                REG_DATA: rdata_q <= bus_bytesel_i ? latch_q[7:0] : latch_q[15:8];
                REG_CTRL: rdata_q <= bus_bytesel_i ? {6'b000000, ena_q, busy} : 8'h00;
                default:  rdata_q <= 8'h00;
            endcase
        end
    end

    assign bus_data_o   = rdata_q;
    assign bus_wr_req_o = wr_req_q;
    assign bus_rd_req_o = rd_req_q;
    assign bus_addr_o   = addr_q;
    assign bus_wdata_o  = wdata_q;
    assign video_ena_o  = ena_q;

endmodule

`default_nettype wire

/* design/xv_video_gen.sv */
`default_nettype none
`timescale 1ns/1ns

module xv_video_gen (
    input  logic                        clk,            // pixel clock
    input  logic                        rst_n_i,
    input  logic                        enable_i,       // video enable from control reg
    input  logic [xv_pkg::VRAM_DW-1:0]  vram_data_i,    // word fetched last cycle
    output logic                        vid_rd_o,       // fetch request, wins the vram
    output logic [xv_pkg::VRAM_AW-1:0]  vid_addr_o,
    output logic [3:0]                  red_o,
    output logic [3:0]                  green_o,
    output logic [3:0]                  blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);
    import xv_pkg::*;

    logic [H_CW-1:0] h_cnt;     // pixel in line
    logic [V_CW-1:0] v_cnt;     // line in frame
    logic            de_now;    // visible at the counters
    logic            hs_now;    // in horizontal sync window
    logic            vs_now;    // in vertical sync window
    logic            de_q1;     // stage 1, aligned with returning data
    logic            hs_q1;
    logic            vs_q1;
    logic            fetch_q1;  // word on vram_data_i is ours

    // raster counters, free running
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_CW'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == V_CW'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_comb begin
        de_now = (h_cnt < H_CW'(H_VISIBLE)) && (v_cnt < V_CW'(V_VISIBLE));
        hs_now = (h_cnt >= H_CW'(H_VISIBLE + H_FRONT)) &&
                 (h_cnt <  H_CW'(H_VISIBLE + H_FRONT + H_SYNC));
        vs_now = (v_cnt >= V_CW'(V_VISIBLE + V_FRONT)) &&
                 (v_cnt <  V_CW'(V_VISIBLE + V_FRONT + V_SYNC));
        // one fetch per visible pixel, none while disabled
        vid_rd_o   = de_now && enable_i;
        vid_addr_o = VRAM_AW'(v_cnt * H_VISIBLE + h_cnt);   // scan order, base 0
    end

    // pipeline, latency 2 from counters to pins
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_q1    <= 1'b0;
            hs_q1    <= ~SYNC_ACTIVE;
            vs_q1    <= ~SYNC_ACTIVE;
            fetch_q1 <= 1'b0;
            dv_de_o  <= 1'b0;
            hsync_o  <= ~SYNC_ACTIVE;
            vsync_o  <= ~SYNC_ACTIVE;
            red_o    <= 4'h0;
            green_o  <= 4'h0;
            blue_o   <= 4'h0;
        end else begin
            de_q1    <= de_now;
            hs_q1    <= hs_now ? SYNC_ACTIVE : ~SYNC_ACTIVE;
            vs_q1    <= vs_now ? SYNC_ACTIVE : ~SYNC_ACTIVE;
            fetch_q1 <= vid_rd_o;
            dv_de_o  <= de_q1;
            hsync_o  <= hs_q1;
            vsync_o  <= vs_q1;
            if (fetch_q1) begin             // 12-bit rgb in the low bits
                red_o   <= vram_data_i[11:8];
                green_o <= vram_data_i[7:4];
                blue_o  <= vram_data_i[3:0];
            end else begin                  // blanking or disabled
                red_o   <= 4'h0;
                green_o <= 4'h0;
                blue_o  <= 4'h0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/xv_top.sv */
`default_nettype none
`timescale 1ns/1ns

module xv_top (
    input  logic        clk,            // pixel clock
    input  logic        rst_n_i,
    input  logic        bus_cs_n_i,     // register select strobe, active low
    input  logic        bus_rd_nwr_i,   // 1 read, 0 write
    input  logic [3:0]  bus_reg_num_i,
    input  logic        bus_bytesel_i,  // 0 even byte, 1 odd byte
    input  logic [7:0]  bus_data_i,
    output logic [7:0]  bus_data_o,
    output logic [3:0]  red_o,
    output logic [3:0]  green_o,
    output logic [3:0]  blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o         // display enable
);
    import xv_pkg::*;

    logic               video_ena;      // control reg bit 0
    logic               bus_wr_req;
    logic               bus_rd_req;
    logic [VRAM_AW-1:0] bus_addr;
    logic [VRAM_DW-1:0] bus_wdata;
    logic               bus_ack;
    logic               bus_rd_valid;
    logic               vid_rd;
    logic [VRAM_AW-1:0] vid_addr;
    logic [VRAM_DW-1:0] mem_rdata;      // shared by both requesters

    xv_bus_regs bus_regs0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .bus_ack_i      (bus_ack),
        .bus_rd_valid_i (bus_rd_valid),
        .mem_rdata_i    (mem_rdata),
        .bus_data_o     (bus_data_o),
        .bus_wr_req_o   (bus_wr_req),
        .bus_rd_req_o   (bus_rd_req),
        .bus_addr_o     (bus_addr),
        .bus_wdata_o    (bus_wdata),
        .video_ena_o    (video_ena)
    );

    xv_video_gen video_gen0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .enable_i    (video_ena),
        .vram_data_i (mem_rdata),
        .vid_rd_o    (vid_rd),
        .vid_addr_o  (vid_addr),
        .red_o       (red_o),
        .green_o     (green_o),
        .blue_o      (blue_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .dv_de_o     (dv_de_o)
    );

    xv_vram_ctrl vram_ctrl0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .vid_rd_i       (vid_rd),
        .vid_addr_i     (vid_addr),
        .bus_wr_req_i   (bus_wr_req),
        .bus_rd_req_i   (bus_rd_req),
        .bus_addr_i     (bus_addr),
        .bus_wdata_i    (bus_wdata),
        .bus_ack_o      (bus_ack),
        .bus_rd_valid_o (bus_rd_valid),
        .mem_rdata_o    (mem_rdata)
    );

endmodule

`default_nettype wire

/* verif/tb_xv.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_xv;
    import xv_pkg::*;

    localparam int N_WORDS     = V_VISIBLE * H_VISIBLE;    // one word per visible pixel
    localparam int FRAME       = V_TOTAL * H_TOTAL;        // cycles per frame
    localparam int POLL_MAX    = 4 * H_TOTAL;              // status polls before giving up
    localparam int CYCLE_LIMIT = 6000;                     // about 4x the test length

    logic       clk;
    logic       rst_n_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    logic [VRAM_DW-1:0] model_mem [0:255];     // expected vram contents
    logic               model_ok  [0:255];     // word has been written
    logic [VRAM_AW-1:0] model_addr;            // mirrors the dut pointer
    integer             seed;
    int                 err_cnt;               // wrong values
    int                 fail_cnt;              // other failures
    logic               scan_check;            // pixels must match the model
    logic               blank_check;           // rgb must stay black
    logic [7:0]         pix_idx;               // pixel position in frame

    // raster monitor state
    logic hs_q;
    logic vs_q;
    logic de_q;
    logic hs_seen;
    logic vs_seen;
    int   hs_low_len;
    int   hs_period;
    int   vs_low_len;
    int   vs_period;
    int   de_len;
    int   de_lines;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    xv_top dut0 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o)
    );

    function automatic void expect_equal(input string name, input logic [31:0] exp,
                                         input logic [31:0] got);
        assert (got === exp) else begin
            err_cnt++;
            $display("ERR %0t ns %s expected %0h got %0h", $time, name, exp, got);
        end
    endfunction

    function automatic void check_reset_state();
        expect_equal("hsync_o", !SYNC_ACTIVE, hsync_o);    // syncs idle high
        expect_equal("vsync_o", !SYNC_ACTIVE, vsync_o);
        expect_equal("dv_de_o", 0, dv_de_o);
        expect_equal("rgb", 0, {red_o, green_o, blue_o});
        expect_equal("bus_data_o", 0, bus_data_o);
    endfunction

    // one-cycle select strobe
    task automatic bus_write(input logic [3:0] reg_num, input logic odd, input logic [7:0] data);
        @(posedge clk);
        bus_cs_n_i    <= CS_ENABLED;
        bus_rd_nwr_i  <= RNW_WRITE;
        bus_reg_num_i <= reg_num;
        bus_bytesel_i <= odd;
        bus_data_i    <= data;
        @(posedge clk);
        bus_cs_n_i    <= !CS_ENABLED;
    endtask

    task automatic bus_read(input logic [3:0] reg_num, input logic odd, output logic [7:0] data);
        @(posedge clk);
        bus_cs_n_i    <= CS_ENABLED;
        bus_rd_nwr_i  <= RNW_READ;
        bus_reg_num_i <= reg_num;
        bus_bytesel_i <= odd;
        @(posedge clk);
        bus_cs_n_i    <= !CS_ENABLED;
        @(posedge clk);
        data = bus_data_o;          // registered the edge before
    endtask

    task automatic wait_idle();
        logic [7:0] status;
        int         polls;
        status = 8'h01;
        polls  = 0;
        while (status[0] && polls < POLL_MAX) begin
            bus_read(REG_CTRL, 1'b1, status);
            polls++;
        end
        assert (!status[0]) else begin
            fail_cnt++;
            $display("busy still set after %0d status polls at %0t ns", polls, $time);
        end
    endtask

    task automatic set_addr(input logic [VRAM_AW-1:0] addr);
        bus_write(REG_ADDR, 1'b0, 8'h00);
        bus_write(REG_ADDR, 1'b1, addr);       // also starts the prefetch
        model_addr = addr;
        wait_idle();
    endtask

    task automatic write_word(input logic [VRAM_DW-1:0] word);
        bus_write(REG_DATA, 1'b0, word[15:8]);
        bus_write(REG_DATA, 1'b1, word[7:0]);
        model_mem[model_addr] = word;
        model_ok[model_addr]  = 1'b1;
        model_addr = model_addr + 1'b1;        // wraps like the pointer
        wait_idle();
    endtask

    task automatic check_readback(input logic [VRAM_AW-1:0] addr);
        logic [7:0] hi;
        logic [7:0] lo;
        set_addr(addr);
        bus_read(REG_DATA, 1'b0, hi);
        bus_read(REG_DATA, 1'b1, lo);
        expect_equal("bus_data_o latch", model_mem[addr], {hi, lo});
    endtask

    // sync and enable shapes, sampled each edge
    always @(posedge clk) begin
        if (!rst_n_i) begin
            hs_q     <= !SYNC_ACTIVE;
            vs_q     <= !SYNC_ACTIVE;
            de_q     <= 1'b0;
            hs_seen  <= 1'b0;
            vs_seen  <= 1'b0;
            hs_period <= 0;
            vs_period <= 0;
            de_lines <= 0;
        end else begin
            hs_q <= hsync_o;
            vs_q <= vsync_o;
            de_q <= dv_de_o;
            if (hs_q != SYNC_ACTIVE && hsync_o == SYNC_ACTIVE) begin  // hsync falls
                if (hs_seen) expect_equal("hsync_o period", H_TOTAL, hs_period);
                hs_seen    <= 1'b1;
                hs_period  <= 1;
                hs_low_len <= 1;
            end else begin
                hs_period <= hs_period + 1;
                if (hsync_o == SYNC_ACTIVE) hs_low_len <= hs_low_len + 1;
            end
            if (hs_q == SYNC_ACTIVE && hsync_o != SYNC_ACTIVE)
                expect_equal("hsync_o low length", H_SYNC, hs_low_len);
            if (vs_q != SYNC_ACTIVE && vsync_o == SYNC_ACTIVE) begin  // frame boundary
                if (vs_seen) expect_equal("vsync_o period", FRAME, vs_period);
                expect_equal("dv_de_o lines per frame", V_VISIBLE, de_lines);
                vs_seen    <= 1'b1;
                vs_period  <= 1;
                vs_low_len <= 1;
                de_lines   <= 0;
            end else begin
                vs_period <= vs_period + 1;
                if (vsync_o == SYNC_ACTIVE) vs_low_len <= vs_low_len + 1;
            end
            if (vs_q == SYNC_ACTIVE && vsync_o != SYNC_ACTIVE)
                expect_equal("vsync_o low length", V_SYNC * H_TOTAL, vs_low_len);
            if (!de_q && dv_de_o) de_len <= 1;
            else if (dv_de_o) de_len <= de_len + 1;
            if (de_q && !dv_de_o) begin        // end of a visible run
                expect_equal("dv_de_o run length", H_VISIBLE, de_len);
                de_lines <= de_lines + 1;
            end
        end
    end

    // pixel position in scan order, restarts in vsync
    always @(posedge clk) begin
        if (!rst_n_i || vsync_o == SYNC_ACTIVE) begin
            pix_idx <= 8'd0;
        end else if (dv_de_o) begin
            if (scan_check && pix_idx < N_WORDS && model_ok[pix_idx])
                expect_equal("rgb pixel", model_mem[pix_idx][11:0], {red_o, green_o, blue_o});
            pix_idx <= pix_idx + 1'b1;
        end
    end

    de_outside_sync: assert property (@(posedge clk) disable iff (!rst_n_i)
        dv_de_o |-> (hsync_o != SYNC_ACTIVE && vsync_o != SYNC_ACTIVE))
    else begin
        fail_cnt++;
        $display("display enable high during a sync pulse at %0t ns", $time);
    end

    rgb_black: assert property (@(posedge clk) disable iff (!rst_n_i)
        (blank_check && dv_de_o) |-> ({red_o, green_o, blue_o} == 12'h000))
    else begin
        err_cnt++;
        $display("ERR %0t ns rgb expected 0 got %0h", $time, $sampled({red_o, green_o, blue_o}));
    end

    initial begin : stimulus
        logic [7:0] status;
        logic [7:0] pick;
        int         i;
        seed = 32'hddd9;
        err_cnt  = 0;
        fail_cnt = 0;
        model_addr = '0;
        for (i = 0; i < 256; i++) begin
            model_ok[i] = 1'b0;
        end
        rst_n_i       <= 1'b0;
        bus_cs_n_i    <= !CS_ENABLED;
        bus_rd_nwr_i  <= RNW_READ;
        bus_reg_num_i <= 4'h0;
        bus_bytesel_i <= 1'b0;
        bus_data_i    <= 8'h00;
        scan_check    <= 1'b0;
        blank_check   <= 1'b1;         // video starts disabled
        @(posedge clk);
        repeat (2) begin
            @(posedge clk);
            check_reset_state();
        end
        rst_n_i <= 1'b1;
        @(posedge clk);
        @(negedge clk);                // first cycle out of reset
        check_reset_state();

        repeat (3 * FRAME) @(posedge clk);    // raster only, video off

        // enable, then fill the frame while the raster runs
        blank_check <= 1'b0;
        bus_write(REG_CTRL, 1'b1, 8'h01);
        bus_read(REG_CTRL, 1'b1, status);
        expect_equal("bus_data_o ctrl", 8'h02, status);
        set_addr(8'd0);
        for (i = 0; i < N_WORDS; i++) begin
            write_word(16'($random(seed)));
        end
        scan_check <= 1'b1;
        repeat (3 * FRAME) @(posedge clk);

        // pointer wrap 254, 255, 0
        scan_check <= 1'b0;
        set_addr(8'd254);
        for (i = 0; i < 3; i++) begin
            write_word(16'($random(seed)));
        end
        scan_check <= 1'b1;
        check_readback(8'd254);
        check_readback(8'd255);
        check_readback(8'd0);
        repeat (2 * FRAME) @(posedge clk);    // pixel 0 shows the new word

        // random read-back inside the written words
        for (i = 0; i < 6; i++) begin
            pick = 8'($random(seed) & (N_WORDS - 1));
            check_readback(pick);
        end
        check_readback(8'd255);

        // disable, timing keeps running
        scan_check <= 1'b0;
        bus_write(REG_CTRL, 1'b1, 8'h00);
        repeat (3) @(posedge clk);            // pipeline drains
        blank_check <= 1'b1;
        repeat (3 * FRAME) @(posedge clk);

        repeat (2) @(posedge clk);
        $display("checks done: %0d value errors, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("checks done: %0d value errors, %0d other failures", err_cnt, fail_cnt);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/xv_pkg.sv
design/xv_vram.sv
design/xv_vram_ctrl.sv
design/xv_bus_regs.sv
design/xv_video_gen.sv
design/xv_top.sv
verif/tb_xv.sv

/* run_sim.sh */
#!/bin/sh
# build and run the xv testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_xv_sim

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    -f sim.f --top-module tb_xv -Mdir obj_dir -o tb_xv_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log only
if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
